// File: logic/ex_op_pkg.sv
// execute stage operation codes
`default_nettype none

package ex_op_pkg;

    // operation code as delivered by decode
    typedef logic [7:0] aluop_t;

    localparam aluop_t OP_NOP   = 8'b0000_0000;

    // logic group
    localparam aluop_t OP_AND   = 8'b0010_0100;
    localparam aluop_t OP_OR    = 8'b0010_0101;
    localparam aluop_t OP_XOR   = 8'b0010_0110;
    localparam aluop_t OP_NOR   = 8'b0010_0111;

    // shift group
    localparam aluop_t OP_SLL   = 8'b0111_1100;
    localparam aluop_t OP_SRL   = 8'b0000_0010;
    localparam aluop_t OP_SRA   = 8'b0000_0011;

    // arithmetic group
    localparam aluop_t OP_ADD   = 8'b0010_0000;
    localparam aluop_t OP_ADDU  = 8'b0010_0001;
    localparam aluop_t OP_SUB   = 8'b0010_0010;
    localparam aluop_t OP_SUBU  = 8'b0010_0011;
    localparam aluop_t OP_SLT   = 8'b0010_1010;
    localparam aluop_t OP_SLTU  = 8'b0010_1011;

    // hi/lo producers and moves
    localparam aluop_t OP_MULT  = 8'b0001_1000;
    localparam aluop_t OP_MULTU = 8'b0001_1001;
    localparam aluop_t OP_DIV   = 8'b0001_1010;
    localparam aluop_t OP_DIVU  = 8'b0001_1011;
    localparam aluop_t OP_MFHI  = 8'b0001_0000;
    localparam aluop_t OP_MTHI  = 8'b0001_0001;
    localparam aluop_t OP_MFLO  = 8'b0001_0010;
    localparam aluop_t OP_MTLO  = 8'b0001_0011;

    // result group of a write-back value
    typedef logic [2:0] res_sel_t;

    localparam res_sel_t RES_NONE  = 3'b000;
    localparam res_sel_t RES_LOGIC = 3'b001;
    localparam res_sel_t RES_SHIFT = 3'b010;
    localparam res_sel_t RES_MOVE  = 3'b011;
    localparam res_sel_t RES_ARITH = 3'b100;

endpackage

`default_nettype wire

// File: logic/ex_data_pkg.sv
// execute stage data types
`default_nettype none

package ex_data_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // flat 64-bit arithmetic result, or the hi and lo words as stored
    typedef union packed {
        logic [2*WORD_W-1:0] full;
        struct packed {
            word_t hi;
            word_t lo;
        } parts;
    } hilo_u;

    // one quotient bit per step
    localparam int DIV_STEPS = 32;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);

    localparam logic [DIV_CNT_W-1:0] DIV_LAST = DIV_CNT_W'(DIV_STEPS - 1);

endpackage

`default_nettype wire

// File: logic/div_if.sv
// divider request and result bus
`default_nettype none

interface div_if;

    logic                 start;
    logic                 signed_op;
    ex_data_pkg::word_t   dividend;
    ex_data_pkg::word_t   divisor;
    logic                 ready;
    ex_data_pkg::hilo_u   result;

    // the divisor output is driven from reg2 at the top level
    modport ctrl (
        output start, signed_op, dividend, divisor,
        input  ready, result
    );

    modport div (
        input  start, signed_op, dividend, divisor,
        output ready, result
    );

endinterface

`default_nettype wire

// File: logic/alu_unit.sv
// integer ALU
`default_nettype none

module alu_unit (
    input  ex_op_pkg::aluop_t    aluop_i,
    input  ex_data_pkg::word_t   reg1_i,
    input  ex_data_pkg::word_t   reg2_i,
    input  ex_op_pkg::res_sel_t  res_sel_i,
    output ex_data_pkg::word_t   result_o,
    output logic                 ov_o
);

    logic               sub_op;
    logic               lt_signed;
    logic               lt_unsigned;
    ex_data_pkg::word_t addend;
    ex_data_pkg::word_t sum;
    ex_data_pkg::word_t logic_res;
    ex_data_pkg::word_t shift_res;
    ex_data_pkg::word_t arith_res;

    // one adder serves add, sub and the signed compare
    assign sub_op = (aluop_i == ex_op_pkg::OP_SUB) || (aluop_i == ex_op_pkg::OP_SUBU) ||
                    (aluop_i == ex_op_pkg::OP_SLT);
    assign addend = sub_op ? -reg2_i : reg2_i;
    assign sum    = reg1_i + addend;

    // operand signs agree (reg2 flipped for sub) but the sum sign differs
    assign ov_o = ((aluop_i == ex_op_pkg::OP_ADD) || (aluop_i == ex_op_pkg::OP_SUB)) &&
                  (reg1_i[31] == (reg2_i[31] ^ sub_op)) && (sum[31] != reg1_i[31]);

    // difference sign decides only when the operand signs match
    assign lt_signed   = (reg1_i[31] && !reg2_i[31]) ||
                         ((reg1_i[31] == reg2_i[31]) && sum[31]);
    assign lt_unsigned = reg1_i < reg2_i;

    always_comb
    begin
        case (aluop_i)
            ex_op_pkg::OP_AND:  logic_res = reg1_i & reg2_i;
            ex_op_pkg::OP_OR:   logic_res = reg1_i | reg2_i;
            ex_op_pkg::OP_XOR:  logic_res = reg1_i ^ reg2_i;
            ex_op_pkg::OP_NOR:  logic_res = ~(reg1_i | reg2_i);
            default:            logic_res = '0;
        endcase

        // shift amount from reg1, value from reg2
        case (aluop_i)
            ex_op_pkg::OP_SLL:  shift_res = reg2_i << reg1_i[4:0];
            ex_op_pkg::OP_SRL:  shift_res = reg2_i >> reg1_i[4:0];
            ex_op_pkg::OP_SRA:  shift_res = $signed(reg2_i) >>> reg1_i[4:0];
            default:            shift_res = '0;
        endcase

        case (aluop_i)
            ex_op_pkg::OP_SLT:  arith_res = ex_data_pkg::word_t'(lt_signed);
            ex_op_pkg::OP_SLTU: arith_res = ex_data_pkg::word_t'(lt_unsigned);
            ex_op_pkg::OP_ADD, ex_op_pkg::OP_ADDU,
            ex_op_pkg::OP_SUB, ex_op_pkg::OP_SUBU:
                                arith_res = sum;
            default:            arith_res = '0;
        endcase

        case (res_sel_i)
            ex_op_pkg::RES_LOGIC: result_o = logic_res;
            ex_op_pkg::RES_SHIFT: result_o = shift_res;
            ex_op_pkg::RES_ARITH: result_o = arith_res;
            default:              result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/mul_unit.sv
// 32x32 multiplier
`default_nettype none

module mul_unit (
    input  ex_op_pkg::aluop_t    aluop_i,
    input  ex_data_pkg::word_t   reg1_i,
    input  ex_data_pkg::word_t   reg2_i,
    output ex_data_pkg::hilo_u   product_o
);

    logic                                is_signed;
    logic                                neg_prod;
    ex_data_pkg::word_t                  mcand;
    ex_data_pkg::word_t                  mplier;
    logic [2*ex_data_pkg::WORD_W-1:0]    mag_prod;

    assign is_signed = aluop_i == ex_op_pkg::OP_MULT;
    assign neg_prod  = is_signed && (reg1_i[31] ^ reg2_i[31]);

    // magnitudes for mult, raw operands for multu
    assign mcand  = (is_signed && reg1_i[31]) ? -reg1_i : reg1_i;
    assign mplier = (is_signed && reg2_i[31]) ? -reg2_i : reg2_i;

    assign mag_prod = {{ex_data_pkg::WORD_W{1'b0}}, mcand} *
                      {{ex_data_pkg::WORD_W{1'b0}}, mplier};

    always_comb
    begin
        product_o.full = neg_prod ? -mag_prod : mag_prod;
    end

endmodule

`default_nettype wire

// File: logic/div_unit.sv
// iterative restoring divider
`default_nettype none

module div_unit (
    input  logic clk,
    input  logic rst_n_i,
    div_if.div   div
);

    logic                               running_q;
    logic                               ready_q;
    logic [ex_data_pkg::DIV_CNT_W-1:0]  cnt_q;
    ex_data_pkg::word_t                 rem_q;
    ex_data_pkg::word_t                 quo_q;
    ex_data_pkg::word_t                 dsor_q;
    logic                               neg_quo_q;
    logic                               neg_rem_q;
    ex_data_pkg::word_t                 dvd_mag;
    ex_data_pkg::word_t                 dsor_mag;
    logic [ex_data_pkg::WORD_W:0]       shifted;
    logic [ex_data_pkg::WORD_W:0]       diff;
    ex_data_pkg::word_t                 quo_fix;
    ex_data_pkg::word_t                 rem_fix;
    ex_data_pkg::hilo_u                 result;

    assign dvd_mag  = (div.signed_op && div.dividend[31]) ? -div.dividend : div.dividend;
    assign dsor_mag = (div.signed_op && div.divisor[31]) ? -div.divisor : div.divisor;

    // bring in the next dividend bit and try the subtraction
    assign shifted = {rem_q, quo_q[31]};
    assign diff    = shifted - {1'b0, dsor_q};

    // step counter and done pulse
    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            running_q <= 1'b0;
            ready_q   <= 1'b0;
            cnt_q     <= '0;
        end
        else
        begin
            ready_q <= 1'b0;
            if (div.start && !running_q)
            begin
                running_q <= 1'b1;
                cnt_q     <= '0;
            end
            else if (running_q)
            begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == ex_data_pkg::DIV_LAST)
                begin
                    running_q <= 1'b0;
                    ready_q   <= 1'b1;
                end
            end
        end
    end

    // zero divisor falls out as all-ones quotient and remainder = dividend
    always_ff @(posedge clk)
    begin
        if (div.start && !running_q)
        begin
            rem_q     <= '0;
            quo_q     <= dvd_mag;
            dsor_q    <= dsor_mag;
            neg_quo_q <= div.signed_op && (div.dividend[31] ^ div.divisor[31]);
            neg_rem_q <= div.signed_op && div.dividend[31];
        end
        else if (running_q)
        begin
            rem_q <= diff[32] ? shifted[31:0] : diff[31:0];
            quo_q <= {quo_q[30:0], !diff[32]};
        end
    end

    // quotient truncates toward zero, remainder follows the dividend
    assign quo_fix = neg_quo_q ? -quo_q : quo_q;
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;

    always_comb
    begin
        result.full = {rem_fix, quo_fix};
    end

    assign div.result = result;
    assign div.ready  = ready_q;

endmodule

`default_nettype wire

// File: logic/ex_ctrl.sv
// execute stage control and write-back register
`default_nettype none

module ex_ctrl (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     valid_i,
    input  ex_op_pkg::aluop_t        aluop_i,
    input  ex_data_pkg::word_t       reg1_i,
    input  ex_data_pkg::reg_addr_t   wd_i,
    input  logic                     wreg_i,
    input  ex_data_pkg::word_t       alu_result_i,
    input  logic                     alu_ov_i,
    input  ex_data_pkg::hilo_u       product_i,
    div_if.ctrl                      div,
    output ex_op_pkg::res_sel_t      res_sel_o,
    output logic                     stall_o,
    output logic                     valid_o,
    output ex_data_pkg::reg_addr_t   wd_o,
    output logic                     wreg_o,
    output ex_data_pkg::word_t       wdata_o,
    output logic                     ov_o
);

    logic               is_div;
    logic               accept;
    logic               div_busy_q;
    ex_data_pkg::hilo_u hilo_q;
    ex_data_pkg::word_t wdata_d;

    // result group per operation code
    always_comb
    begin
        case (aluop_i)
            ex_op_pkg::OP_AND, ex_op_pkg::OP_OR, ex_op_pkg::OP_XOR, ex_op_pkg::OP_NOR:
                res_sel_o = ex_op_pkg::RES_LOGIC;
            ex_op_pkg::OP_SLL, ex_op_pkg::OP_SRL, ex_op_pkg::OP_SRA:
                res_sel_o = ex_op_pkg::RES_SHIFT;
            ex_op_pkg::OP_ADD, ex_op_pkg::OP_ADDU, ex_op_pkg::OP_SUB, ex_op_pkg::OP_SUBU,
            ex_op_pkg::OP_SLT, ex_op_pkg::OP_SLTU:
                res_sel_o = ex_op_pkg::RES_ARITH;
            ex_op_pkg::OP_MFHI, ex_op_pkg::OP_MFLO:
                res_sel_o = ex_op_pkg::RES_MOVE;
            default:
                res_sel_o = ex_op_pkg::RES_NONE;
        endcase
    end

    assign is_div = (aluop_i == ex_op_pkg::OP_DIV) || (aluop_i == ex_op_pkg::OP_DIVU);

    // kick the divider once, then hold the stage until ready
    assign div.start     = valid_i && is_div && !div_busy_q;
    assign div.signed_op = aluop_i == ex_op_pkg::OP_DIV;
    assign div.dividend  = reg1_i;

    assign stall_o = valid_i && is_div && !div.ready;
    assign accept  = valid_i && !stall_o;

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
            div_busy_q <= 1'b0;
        else if (div.start)
            div_busy_q <= 1'b1;
        else if (div.ready)
            div_busy_q <= 1'b0;
    end

    // hi holds the remainder and lo the quotient after a divide
    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
            hilo_q <= '0;
        else if (accept)
        begin
            case (aluop_i)
                ex_op_pkg::OP_MULT, ex_op_pkg::OP_MULTU: hilo_q <= product_i;
                ex_op_pkg::OP_DIV, ex_op_pkg::OP_DIVU:   hilo_q <= div.result;
                ex_op_pkg::OP_MTHI:                      hilo_q.parts.hi <= reg1_i;
                ex_op_pkg::OP_MTLO:                      hilo_q.parts.lo <= reg1_i;
                default:                                 ;
            endcase
        end
    end

    always_comb
    begin
        if (aluop_i == ex_op_pkg::OP_MFHI)
            wdata_d = hilo_q.parts.hi;
        else if (aluop_i == ex_op_pkg::OP_MFLO)
            wdata_d = hilo_q.parts.lo;
        else
            wdata_d = alu_result_i;
    end

    // no register write for overflow or for ops without a result group
    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            valid_o <= 1'b0;
            wreg_o  <= 1'b0;
            ov_o    <= 1'b0;
        end
        else
        begin
            valid_o <= accept;
            wreg_o  <= accept && wreg_i && !alu_ov_i && (res_sel_o != ex_op_pkg::RES_NONE);
            ov_o    <= accept && alu_ov_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            wd_o    <= wd_i;
            wdata_o <= wdata_d;
        end
    end

endmodule

`default_nettype wire

// File: logic/ex_top.sv
// execute stage top level
`default_nettype none

module ex_top (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     valid_i,
    input  ex_op_pkg::aluop_t        aluop_i,
    input  ex_data_pkg::word_t       reg1_i,
    input  ex_data_pkg::word_t       reg2_i,
    input  ex_data_pkg::reg_addr_t   wd_i,
    input  logic                     wreg_i,
    output logic                     stall_o,
    output logic                     valid_o,
    output ex_data_pkg::reg_addr_t   wd_o,
    output logic                     wreg_o,
    output ex_data_pkg::word_t       wdata_o,
    output logic                     ov_o
);

    ex_op_pkg::res_sel_t res_sel;
    ex_data_pkg::word_t  alu_result;
    logic                alu_ov;
    ex_data_pkg::hilo_u  product;

    div_if u_div_if ();

    // divisor is taken from reg2 directly
    assign u_div_if.divisor = reg2_i;

    alu_unit u_alu (
        .aluop_i   (aluop_i),
        .reg1_i    (reg1_i),
        .reg2_i    (reg2_i),
        .res_sel_i (res_sel),
        .result_o  (alu_result),
        .ov_o      (alu_ov)
    );

    mul_unit u_mul (
        .aluop_i   (aluop_i),
        .reg1_i    (reg1_i),
        .reg2_i    (reg2_i),
        .product_o (product)
    );

    div_unit u_div (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .div     (u_div_if.div)
    );

    ex_ctrl u_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .aluop_i      (aluop_i),
        .reg1_i       (reg1_i),
        .wd_i         (wd_i),
        .wreg_i       (wreg_i),
        .alu_result_i (alu_result),
        .alu_ov_i     (alu_ov),
        .product_i    (product),
        .div          (u_div_if.ctrl),
        .res_sel_o    (res_sel),
        .stall_o      (stall_o),
        .valid_o      (valid_o),
        .wd_o         (wd_o),
        .wreg_o       (wreg_o),
        .wdata_o      (wdata_o),
        .ov_o         (ov_o)
    );

endmodule

`default_nettype wire

// File: verification/ex_vectors.svh
// execute stage test vectors
`ifndef EX_VECTORS_SVH
`define EX_VECTORS_SVH

typedef struct packed {
    ex_op_pkg::aluop_t      aluop;
    ex_data_pkg::word_t     reg1;
    ex_data_pkg::word_t     reg2;
    ex_data_pkg::reg_addr_t wd;
    logic                   wreg;
    ex_data_pkg::word_t     exp_wdata;
    logic                   exp_wreg;
    logic                   exp_ov;
    logic                   chk_data;
} vector_t;

localparam int NUM_VECTORS = 35;

// aluop, reg1, reg2, wd, wreg, expected wdata, expected wreg, expected ov, compare wdata
localparam vector_t VECTORS [NUM_VECTORS] = '{
    '{ex_op_pkg::OP_MFHI, 32'h00000000, 32'h00000000, 5'd1, 1'b1, 32'h00000000, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_AND, 32'hF0F01234, 32'h0FF0FF00, 5'd2, 1'b1, 32'h00F01200, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_OR, 32'hF0F01234, 32'h0FF0FF00, 5'd3, 1'b1, 32'hFFF0FF34, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_XOR, 32'hF0F01234, 32'h0FF0FF00, 5'd4, 1'b1, 32'hFF00ED34, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_NOR, 32'hF0F01234, 32'h0FF0FF00, 5'd5, 1'b1, 32'h000F00CB, 1'b1, 1'b0, 1'b1},
    // shift amount 4 with bit 5 of reg1 ignored
    '{ex_op_pkg::OP_SLL, 32'h00000024, 32'h800000F1, 5'd6, 1'b1, 32'h00000F10, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_SRL, 32'h00000024, 32'h800000F1, 5'd7, 1'b1, 32'h0800000F, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_SRA, 32'h00000024, 32'h800000F1, 5'd8, 1'b1, 32'hF800000F, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_ADD, 32'h7FFFFFFF, 32'h00000001, 5'd9, 1'b1, 32'h80000000, 1'b0, 1'b1, 1'b1},
    '{ex_op_pkg::OP_ADDU, 32'h7FFFFFFF, 32'h00000001, 5'd10, 1'b1, 32'h80000000, 1'b1, 1'b0, 1'b1},
    // mixed signs carry out without a signed overflow
    '{ex_op_pkg::OP_ADD, 32'hFFFFFFFF, 32'h00000001, 5'd9, 1'b1, 32'h00000000, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_SUB, 32'h80000000, 32'h00000001, 5'd11, 1'b1, 32'h7FFFFFFF, 1'b0, 1'b1, 1'b1},
    '{ex_op_pkg::OP_SUBU, 32'h80000000, 32'h00000001, 5'd12, 1'b1, 32'h7FFFFFFF, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_SLT, 32'hFFFFFFF0, 32'h00000005, 5'd13, 1'b1, 32'h00000001, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_SLTU, 32'hFFFFFFF0, 32'h00000005, 5'd14, 1'b1, 32'h00000000, 1'b1, 1'b0, 1'b1},
    // -2 * 3 signed, then -2 * -3 as unsigned words
    '{ex_op_pkg::OP_MULT, 32'hFFFFFFFE, 32'h00000003, 5'd15, 1'b0, 32'h00000000, 1'b0, 1'b0, 1'b0},
    '{ex_op_pkg::OP_MFHI, 32'h00000000, 32'h00000000, 5'd16, 1'b1, 32'hFFFFFFFF, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_MFLO, 32'h00000000, 32'h00000000, 5'd17, 1'b1, 32'hFFFFFFFA, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_MULTU, 32'hFFFFFFFE, 32'hFFFFFFFD, 5'd18, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0},
    '{ex_op_pkg::OP_MFHI, 32'h00000000, 32'h00000000, 5'd19, 1'b1, 32'hFFFFFFFB, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_MFLO, 32'h00000000, 32'h00000000, 5'd20, 1'b1, 32'h00000006, 1'b1, 1'b0, 1'b1},
    // -7 / 2 gives -3 rem -1
    '{ex_op_pkg::OP_DIV, 32'hFFFFFFF9, 32'h00000002, 5'd21, 1'b0, 32'h00000000, 1'b0, 1'b0, 1'b0},
    '{ex_op_pkg::OP_MFHI, 32'h00000000, 32'h00000000, 5'd22, 1'b1, 32'hFFFFFFFF, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_MFLO, 32'h00000000, 32'h00000000, 5'd23, 1'b1, 32'hFFFFFFFD, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_DIVU, 32'hFFFFFFF9, 32'h00000002, 5'd24, 1'b0, 32'h00000000, 1'b0, 1'b0, 1'b0},
    '{ex_op_pkg::OP_MFLO, 32'h00000000, 32'h00000000, 5'd25, 1'b1, 32'h7FFFFFFC, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_MFHI, 32'h00000000, 32'h00000000, 5'd24, 1'b1, 32'h00000001, 1'b1, 1'b0, 1'b1},
    // zero divisor gives an all-ones quotient and remainder = dividend
    '{ex_op_pkg::OP_DIVU, 32'h12345678, 32'h00000000, 5'd26, 1'b0, 32'h00000000, 1'b0, 1'b0, 1'b0},
    '{ex_op_pkg::OP_MFHI, 32'h00000000, 32'h00000000, 5'd27, 1'b1, 32'h12345678, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_MFLO, 32'h00000000, 32'h00000000, 5'd28, 1'b1, 32'hFFFFFFFF, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_MTHI, 32'hAAAA5555, 32'h00000000, 5'd29, 1'b0, 32'h00000000, 1'b0, 1'b0, 1'b0},
    '{ex_op_pkg::OP_MFLO, 32'h00000000, 32'h00000000, 5'd30, 1'b1, 32'hFFFFFFFF, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_MTLO, 32'h13579BDF, 32'h00000000, 5'd31, 1'b0, 32'h00000000, 1'b0, 1'b0, 1'b0},
    '{ex_op_pkg::OP_MFHI, 32'h00000000, 32'h00000000, 5'd0, 1'b1, 32'hAAAA5555, 1'b1, 1'b0, 1'b1},
    '{ex_op_pkg::OP_MFLO, 32'h00000000, 32'h00000000, 5'd1, 1'b1, 32'h13579BDF, 1'b1, 1'b0, 1'b1}
};

`endif

// File: verification/tb_ex.sv
// execute stage testbench
`default_nettype none

module tb_ex;

    localparam int RESET_CYCLES = 4;

    `include "ex_vectors.svh"

    // worst case is a divide on every row
    localparam int CYCLE_LIMIT = NUM_VECTORS * (ex_data_pkg::DIV_STEPS + 4) + RESET_CYCLES;

    logic                   clk;
    logic                   rst_n_i;
    logic                   valid_i;
    ex_op_pkg::aluop_t      aluop_i;
    ex_data_pkg::word_t     reg1_i;
    ex_data_pkg::word_t     reg2_i;
    ex_data_pkg::reg_addr_t wd_i;
    logic                   wreg_i;
    logic                   stall_o;
    logic                   valid_o;
    ex_data_pkg::reg_addr_t wd_o;
    logic                   wreg_o;
    ex_data_pkg::word_t     wdata_o;
    logic                   ov_o;
    int                     cycle_cnt = 0;

    ex_top u_dut (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .aluop_i (aluop_i),
        .reg1_i  (reg1_i),
        .reg2_i  (reg2_i),
        .wd_i    (wd_i),
        .wreg_i  (wreg_i),
        .stall_o (stall_o),
        .valid_o (valid_o),
        .wd_o    (wd_o),
        .wreg_o  (wreg_o),
        .wdata_o (wdata_o),
        .ov_o    (ov_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // divides are the only ops that hold the stage
    function automatic logic is_divide(input ex_op_pkg::aluop_t op);
        return (op == ex_op_pkg::OP_DIV) || (op == ex_op_pkg::OP_DIVU);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("** Error at time %0t: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("test failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("test failed");
            $fatal(1, "timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    initial
    begin
        vector_t v;
        logic    saw_stall;

        rst_n_i = 1'b0;
        valid_i = 1'b0;
        aluop_i = ex_op_pkg::OP_NOP;
        reg1_i  = '0;
        reg2_i  = '0;
        wd_i    = '0;
        wreg_i  = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_value("valid_o", 32'(valid_o), 32'd0);
        check_value("stall_o", 32'(stall_o), 32'd0);

        for (int i = 0; i < NUM_VECTORS; i++)
        begin
            v = VECTORS[i];
            @(posedge clk);
            valid_i <= 1'b1;
            aluop_i <= v.aluop;
            reg1_i  <= v.reg1;
            reg2_i  <= v.reg2;
            wd_i    <= v.wd;
            wreg_i  <= v.wreg;

            // inputs held while the stage stalls
            @(negedge clk);
            saw_stall = 1'b0;
            while (stall_o)
            begin
                saw_stall = 1'b1;
                check_value("valid_o", 32'(valid_o), 32'd0);
                @(negedge clk);
            end
            check_value("stall_o seen", 32'(saw_stall), 32'(is_divide(v.aluop)));

            // result shows one cycle after the acceptance edge
            @(posedge clk);
            valid_i <= 1'b0;
            @(negedge clk);
            check_value("valid_o", 32'(valid_o), 32'd1);
            check_value("wd_o", 32'(wd_o), 32'(v.wd));
            check_value("wreg_o", 32'(wreg_o), 32'(v.exp_wreg));
            check_value("ov_o", 32'(ov_o), 32'(v.exp_ov));
            if (v.chk_data)
                check_value("wdata_o", wdata_o, v.exp_wdata);
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verification
logic/ex_op_pkg.sv
logic/ex_data_pkg.sv
logic/div_if.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/div_unit.sv
logic/ex_ctrl.sv
logic/ex_top.sv
verification/tb_ex.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --timing
TOP       := tb_ex
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST)) $(wildcard verification/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
